/* hw/l2_geom_pkg.sv */
`default_nettype none

package l2_geom_pkg;

    //////////////////////////////////////////////////
    // geometry

    localparam int WAYS           = 4; // 4 ways per set
    localparam int WORDS_PER_LINE = 4;
    localparam int BYTE_OFS       = 2; // byte bits below the word offset

    //////////////////////////////////////////////////
    // word, line and address types

    typedef logic [31:0] l2_word_t;
    typedef l2_word_t [WORDS_PER_LINE-1:0] l2_line_t; // word 0 in the low bits
    typedef logic [31:0] l2_addr_t;

    typedef logic [$clog2(WAYS)-1:0] l2_way_t;
    typedef logic [WAYS-1:0] l2_waymask_t;       // one bit per way

endpackage

`default_nettype wire

/* hw/l2_ctrl_pkg.sv */
`default_nettype none

package l2_ctrl_pkg;

    // main control states
    typedef enum logic [3:0] {
        s_idle,
        s_lookup,
        s_maint_op,
        s_check_dirty,
        s_check_dirty1,
        s_writeback,
        s_refill_req,
        s_refill_wait,
        s_refill_write
    } l2_state_e;

    // who owns the request buffer
    typedef enum logic [1:0] {
        src_none,
        src_icache_read,
        src_dcache_read,
        src_dcache_write
    } l2_src_e;

    // cache maintenance opcodes
    typedef enum logic [1:0] {
        op_index_inv,    // drop one way, no writeback
        op_index_wb_inv, // way picked by address bits
        op_hit_wb_inv
    } l2_maint_e;

endpackage

`default_nettype wire

/* hw/l2_ifs.sv */
`timescale 1ns/10ps
`default_nettype none

// latched request, arbiter to control and arrays
interface l2_req_if import l2_geom_pkg::*, l2_ctrl_pkg::*; ();
    l2_src_e   src;
    logic      is_maint;
    l2_maint_e maint;
    l2_addr_t  addr;
    l2_word_t  wdata;
    logic      accept; // buffer may take a new request

    modport arb   (output src, is_maint, maint, addr, wdata, input accept);
    modport fsm   (input src, is_maint, maint, addr, output accept);
    modport store (input addr, wdata);
endinterface

// tag store lookup results and update strobes
interface l2_lookup_if import l2_geom_pkg::*; #(
    parameter int tag_width = 20
) ();
    l2_waymask_t          hit;
    l2_way_t              victim;     // plru choice
    logic                 dirty;      // of sel way
    logic [tag_width-1:0] victim_tag; // of sel way
    logic                 use_en;
    l2_way_t              use_way;
    logic                 set_dirty;
    logic                 clr_dirty;
    l2_waymask_t          inval;
    logic                 index_init;
    logic                 fill;
    l2_way_t              sel;

    modport fsm  (input hit, victim, dirty,
                  output use_en, use_way, set_dirty, clr_dirty, inval, index_init, fill, sel);
    modport tags (output hit, victim, dirty, victim_tag,
                  input use_en, use_way, set_dirty, clr_dirty, inval, index_init, fill, sel);
endinterface

`default_nettype wire

/* hw/l2_req_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_req_arbiter
    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;
#(
    parameter int index_width  = 8,
    parameter int offset_width = 2
) (
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire logic      icache_req,
    input  wire l2_addr_t  icache_addr,
    input  wire logic      dcache_req,
    input  wire logic      dcache_wr,
    input  wire l2_addr_t  dcache_addr,
    input  wire l2_word_t  dcache_wdata,
    input  wire logic      op_flag,
    input  wire l2_maint_e op_code,
    input  wire l2_addr_t  op_addr,
    output logic           icache_addrok,
    output logic           dcache_addrok,
    l2_req_if.arb          req
);

    localparam int tag_lsb = index_width + offset_width + BYTE_OFS;

    logic grant_op;
    logic grant_d;
    logic grant_i;

    // fixed priority, maintenance > dcache > icache
    assign grant_op = req.accept & op_flag;
    assign grant_d  = req.accept & ~op_flag & dcache_req;
    assign grant_i  = req.accept & ~op_flag & ~dcache_req & icache_req;

    assign dcache_addrok = grant_d;
    assign icache_addrok = grant_i;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req.src      <= src_none;
            req.is_maint <= 1'b0;
        end else if (req.accept) begin
            req.is_maint <= grant_op;
            if (grant_d)
                req.src <= dcache_wr ? src_dcache_write : src_dcache_read;
            else if (grant_i)
                req.src <= src_icache_read;
            else
                req.src <= src_none; // empty buffer, maint included
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (grant_op) begin
            req.maint <= op_code;
            // index ops carry only index and way, tag field cleared
            if (op_code == op_hit_wb_inv)
                req.addr <= op_addr;
            else
                req.addr <= l2_addr_t'(op_addr[tag_lsb-1:0]);
        end else if (grant_d) begin
            req.addr  <= dcache_addr;
            req.wdata <= dcache_wdata;
        end else if (grant_i) begin
            req.addr <= icache_addr;
        end
    end

endmodule

`default_nettype wire

/* hw/l2_tag_store.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_tag_store
    import l2_geom_pkg::*;
#(
    parameter int index_width  = 8,
    parameter int offset_width = 2
) (
    input  wire logic clk,
    input  wire logic rstn,
    l2_req_if.store   req,
    l2_lookup_if.tags lk
);

    localparam int tag_width = 32 - index_width - offset_width - BYTE_OFS;
    localparam int sets      = 1 << index_width;
    localparam int idx_lsb   = offset_width + BYTE_OFS;

    logic [tag_width-1:0] tags [WAYS][sets];
    l2_waymask_t          valid [sets];
    l2_waymask_t          dirty [sets];
    logic [2:0]           plru  [sets]; // [0] root, [1] ways 0/1, [2] ways 2/3

    logic [index_width-1:0] idx;
    logic [tag_width-1:0]   req_tag;
    logic [2:0]             tree;

    assign idx     = req.addr[idx_lsb +: index_width];
    assign req_tag = req.addr[31 -: tag_width];
    assign tree    = plru[idx];

    //////////////////////////////////////////////////
    // lookup

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            lk.hit[w] = valid[idx][w] && (tags[w][idx] == req_tag);
        end
    end

    assign lk.victim     = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
    assign lk.dirty      = valid[idx][lk.sel] & dirty[idx][lk.sel]; // stale dirty ignored
    assign lk.victim_tag = tags[lk.sel][idx];

    //////////////////////////////////////////////////
    // state updates

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < sets; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                plru[s]  <= '0;
            end
        end else begin
            if (lk.fill || lk.index_init)
                valid[idx][lk.sel] <= lk.fill;
            else if (|lk.inval)
                valid[idx] <= valid[idx] & ~lk.inval;

            if (lk.set_dirty || lk.clr_dirty)
                dirty[idx][lk.sel] <= lk.set_dirty;

            if (lk.use_en) begin
                plru[idx][0] <= ~lk.use_way[1]; // point at the other half
                if (lk.use_way[1])
                    plru[idx][2] <= ~lk.use_way[0];
                else
                    plru[idx][1] <= ~lk.use_way[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lk.fill)
            tags[lk.sel][idx] <= req_tag;
        else if (lk.index_init)
            tags[lk.sel][idx] <= '0;
    end

endmodule

`default_nettype wire

/* hw/l2_data_store.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_data_store
    import l2_geom_pkg::*;
#(
    parameter int index_width  = 8,
    parameter int offset_width = 2
) (
    input  wire logic     clk,
    input  wire logic     word_we,
    input  wire logic     fill_we,
    input  wire l2_way_t  way,
    input  wire l2_way_t  rd_way,
    input  wire l2_line_t mem_rline,
    l2_req_if.store       req,
    output l2_line_t      rd_line
);

    localparam int sets    = 1 << index_width;
    localparam int idx_lsb = offset_width + BYTE_OFS;

    l2_line_t lines [WAYS][sets];

    logic [index_width-1:0]  idx;
    logic [offset_width-1:0] ofs;

    assign idx = req.addr[idx_lsb +: index_width];
    assign ofs = req.addr[BYTE_OFS +: offset_width];

    always_ff @(posedge clk) begin
        if (fill_we)
            lines[way][idx] <= mem_rline;      // whole line from memory
        else if (word_we)
            lines[way][idx][ofs] <= req.wdata; // merge one word
    end

    // refill data bypassed so a read miss returns in the fill cycle
    assign rd_line = fill_we ? mem_rline : lines[rd_way][idx];

endmodule

`default_nettype wire

/* hw/l2_main_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_main_fsm
    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;
(
    input  wire logic clk,
    input  wire logic rstn,
    input  wire logic mem_addrok_w,
    input  wire logic mem_addrok_r,
    input  wire logic mem_dataok,
    output logic      mem_req_w,
    output logic      mem_req_r,
    output logic      mem_rdy,
    output logic      icache_dataok,
    output logic      dcache_dataok,
    output logic      word_we,
    output logic      fill_we,
    output l2_way_t   way,
    output l2_way_t   rd_way,
    l2_req_if.fsm     req,
    l2_lookup_if.fsm  lk
);

    l2_state_e state;
    l2_state_e next_state;
    l2_way_t   hit_way;
    l2_way_t   hit_rec;  // hit way kept for hit_wb_inv
    l2_way_t   victim_q;
    l2_way_t   tgt_way;
    l2_way_t   cur_way;
    logic      hit_any;
    logic      is_read;
    logic      ret;
    logic      maint_done;

    function automatic l2_way_t mask_to_way(input l2_waymask_t m);
        l2_way_t w;
        w = '0;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (m[i])
                w = l2_way_t'(i); // lowest set bit wins
        end
        return w;
    endfunction

    assign hit_any = |lk.hit;
    assign hit_way = mask_to_way(lk.hit);
    assign is_read = (req.src == src_icache_read) || (req.src == src_dcache_read);

    //////////////////////////////////////////////////
    // way selection

    always_comb begin
        if (req.is_maint)
            tgt_way = (req.maint == op_hit_wb_inv) ? hit_rec : req.addr[1:0];
        else if (state == s_refill_write)
            tgt_way = victim_q;
        else
            tgt_way = lk.victim;
    end

    assign cur_way    = (state == s_lookup) ? hit_way : tgt_way;
    assign way        = cur_way;
    assign rd_way     = cur_way;
    assign lk.sel     = cur_way;
    assign lk.use_way = cur_way;
    assign lk.inval   = maint_done ? (l2_waymask_t'(1) << tgt_way) : '0;

    assign req.accept = (state == s_idle) ||
                        (state == s_lookup && !req.is_maint &&
                         (req.src == src_none || hit_any));

    assign icache_dataok = ret && (req.src == src_icache_read);
    assign dcache_dataok = ret && (req.src == src_dcache_read);

    always_ff @(posedge clk) begin
        if (!rstn)
            state <= s_idle;
        else
            state <= next_state;
    end

    always_ff @(posedge clk) begin
        victim_q <= lk.victim;
        if (state == s_maint_op)
            hit_rec <= hit_way;
    end

    //////////////////////////////////////////////////
    // next state and strobes

    always_comb begin
        next_state    = state;
        mem_req_w     = 1'b0;
        mem_req_r     = 1'b0;
        mem_rdy       = 1'b0;
        ret           = 1'b0;
        word_we       = 1'b0;
        fill_we       = 1'b0;
        maint_done    = 1'b0;
        lk.use_en     = 1'b0;
        lk.set_dirty  = 1'b0;
        lk.clr_dirty  = 1'b0;
        lk.index_init = 1'b0;
        lk.fill       = 1'b0;
        case (state)
            s_idle: next_state = s_lookup; // buffer reloads here
            s_lookup: begin
                if (req.is_maint) begin
                    next_state = s_maint_op;
                end else if (req.src != src_none) begin
                    if (!hit_any) begin
                        next_state = s_check_dirty;
                    end else begin
                        lk.use_en = 1'b1;
                        if (is_read) begin
                            ret = 1'b1;
                        end else begin
                            word_we      = 1'b1;
                            lk.set_dirty = 1'b1;
                        end
                    end
                end
            end
            s_maint_op: begin
                case (req.maint)
                    op_index_inv: begin
                        lk.index_init = 1'b1;
                        next_state    = s_idle;
                    end
                    op_index_wb_inv: next_state = s_check_dirty;
                    default: next_state = hit_any ? s_check_dirty : s_idle;
                endcase
            end
            s_check_dirty: next_state = s_check_dirty1; // sel settles on target
            s_check_dirty1: begin
                if (lk.dirty) begin
                    next_state = s_writeback;
                end else if (req.is_maint) begin
                    maint_done   = 1'b1;
                    lk.clr_dirty = 1'b1;
                    next_state   = s_idle;
                end else begin
                    next_state = s_refill_req;
                end
            end
            s_writeback: begin
                mem_req_w = 1'b1;
                if (mem_addrok_w) begin
                    if (req.is_maint) begin
                        maint_done   = 1'b1;
                        lk.clr_dirty = 1'b1;
                        next_state   = s_idle;
                    end else begin
                        next_state = s_refill_req;
                    end
                end
            end
            s_refill_req: begin
                mem_req_r = 1'b1;
                if (mem_addrok_r)
                    next_state = s_refill_wait;
            end
            s_refill_wait: begin
                mem_rdy = 1'b1;
                if (mem_dataok) begin
                    fill_we      = 1'b1;
                    lk.fill      = 1'b1;
                    lk.clr_dirty = 1'b1;
                    if (is_read) begin
                        ret        = 1'b1;
                        lk.use_en  = 1'b1;
                        next_state = s_idle;
                    end else begin
                        next_state = s_refill_write; // store word merged next
                    end
                end
            end
            s_refill_write: begin
                word_we      = 1'b1;
                lk.set_dirty = 1'b1;
                lk.use_en    = 1'b1;
                next_state   = s_idle;
            end
            default: next_state = s_idle;
        endcase
    end

endmodule

`default_nettype wire

/* hw/l2_cache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_cache_top
    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;
#(
    parameter int index_width  = 8,
    parameter int offset_width = 2
) (
    input  wire logic      clk,
    input  wire logic      rstn,
    // icache port
    input  wire logic      icache_req,
    input  wire l2_addr_t  icache_addr,
    output logic           icache_addrok,
    output logic           icache_dataok,
    output l2_word_t       icache_rdata,
    // dcache port
    input  wire logic      dcache_req,
    input  wire logic      dcache_wr,
    input  wire l2_addr_t  dcache_addr,
    input  wire l2_word_t  dcache_wdata,
    output logic           dcache_addrok,
    output logic           dcache_dataok,
    output l2_word_t       dcache_rdata,
    // maintenance
    input  wire logic      op_flag,
    input  wire l2_maint_e op_code,
    input  wire l2_addr_t  op_addr,
    output logic           op_busy,
    // memory
    output logic           mem_req_w,
    output l2_addr_t       mem_waddr,
    output l2_line_t       mem_wline,
    input  wire logic      mem_addrok_w,
    output logic           mem_req_r,
    output l2_addr_t       mem_raddr,
    input  wire logic      mem_addrok_r,
    output logic           mem_rdy,
    input  wire logic      mem_dataok,
    input  wire l2_line_t  mem_rline
);

    localparam int tag_width = 32 - index_width - offset_width - BYTE_OFS;
    localparam int idx_lsb   = offset_width + BYTE_OFS;

    l2_req_if req_bus ();
    l2_lookup_if #(.tag_width(tag_width)) lk_bus ();

    logic                    word_we;
    logic                    fill_we;
    l2_way_t                 wr_way;
    l2_way_t                 rd_way;
    l2_line_t                rd_line;
    logic [offset_width-1:0] ofs;

    assign ofs          = req_bus.addr[BYTE_OFS +: offset_width];
    assign icache_rdata = rd_line[ofs];
    assign dcache_rdata = rd_line[ofs];
    assign op_busy      = ~req_bus.accept;
    assign mem_wline    = rd_line;
    assign mem_raddr    = {req_bus.addr[31:idx_lsb], {idx_lsb{1'b0}}};
    assign mem_waddr    = {lk_bus.victim_tag, req_bus.addr[idx_lsb +: index_width],
                           {idx_lsb{1'b0}}}; // evicted line address

    l2_req_arbiter #(.index_width(index_width), .offset_width(offset_width)) u_arb (
        .clk, .rstn, .icache_req, .icache_addr, .dcache_req, .dcache_wr, .dcache_addr,
        .dcache_wdata, .op_flag, .op_code, .op_addr, .icache_addrok, .dcache_addrok,
        .req(req_bus)
    );

    l2_tag_store #(.index_width(index_width), .offset_width(offset_width)) u_tags (
        .clk, .rstn, .req(req_bus), .lk(lk_bus)
    );

    l2_data_store #(.index_width(index_width), .offset_width(offset_width)) u_data (
        .clk, .word_we, .fill_we, .way(wr_way), .rd_way, .mem_rline, .req(req_bus), .rd_line
    );

    l2_main_fsm u_fsm (
        .clk, .rstn, .mem_addrok_w, .mem_addrok_r, .mem_dataok, .mem_req_w, .mem_req_r,
        .mem_rdy, .icache_dataok, .dcache_dataok, .word_we, .fill_we, .way(wr_way), .rd_way,
        .req(req_bus), .lk(lk_bus)
    );

endmodule

`default_nettype wire

/* verification/l2_cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module l2_cache_tb
    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;
();

    localparam int index_width  = 8;
    localparam int offset_width = 2;
    localparam int idx_lsb      = offset_width + BYTE_OFS;
    localparam int tag_lsb      = idx_lsb + index_width;
    localparam int timeout      = 200;          // cycles allowed per wait
    localparam l2_word_t fill_key = 32'h6c1e_93a5; // memory fill pattern

    logic      clk;
    logic      rstn;
    logic      icache_req;
    l2_addr_t  icache_addr;
    logic      icache_addrok;
    logic      icache_dataok;
    l2_word_t  icache_rdata;
    logic      dcache_req;
    logic      dcache_wr;
    l2_addr_t  dcache_addr;
    l2_word_t  dcache_wdata;
    logic      dcache_addrok;
    logic      dcache_dataok;
    l2_word_t  dcache_rdata;
    logic      op_flag;
    l2_maint_e op_code;
    l2_addr_t  op_addr;
    logic      op_busy;
    logic      mem_req_w;
    l2_addr_t  mem_waddr;
    l2_line_t  mem_wline;
    logic      mem_addrok_w;
    logic      mem_req_r;
    l2_addr_t  mem_raddr;
    logic      mem_addrok_r;
    logic      mem_rdy;
    logic      mem_dataok;
    l2_line_t  mem_rline;

    l2_word_t mem_arr [logic [29:0]]; // words the memory model has stored
    l2_word_t shadow  [logic [29:0]]; // latest value written to each word
    l2_word_t exp_i [$];              // expected icache read data, in order
    l2_word_t exp_d [$];
    int       wr_count;
    int       rd_count;
    l2_addr_t last_waddr;             // line address of the latest memory write
    l2_addr_t last_raddr;

    l2_cache_top #(
        .index_width(index_width),
        .offset_width(offset_width)
    ) l2_cache_top_inst (.*);

    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // reference model and checks

    function automatic l2_word_t init_word(input logic [29:0] wa);
        return l2_word_t'(wa) ^ fill_key;
    endfunction

    function automatic l2_word_t ref_word(input l2_addr_t a);
        return shadow.exists(a[31:2]) ? shadow[a[31:2]] : init_word(a[31:2]);
    endfunction

    function automatic l2_word_t mem_word(input l2_addr_t a);
        return mem_arr.exists(a[31:2]) ? mem_arr[a[31:2]] : init_word(a[31:2]);
    endfunction

    function automatic l2_addr_t make_addr(input int tag, input int set, input int word);
        return (l2_addr_t'(tag) << tag_lsb) | (l2_addr_t'(set) << idx_lsb) |
               (l2_addr_t'(word) << BYTE_OFS);
    endfunction

    // index ops carry the way in the byte offset bits
    function automatic l2_addr_t index_op_addr(input int set, input int way);
        return (l2_addr_t'(set) << idx_lsb) | l2_addr_t'(way);
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input l2_word_t exp, input l2_word_t act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input l2_addr_t exp, input l2_addr_t act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_line(input string name, input l2_line_t exp, input l2_line_t act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    // next mid-cycle sample, bounded
    task automatic next_sample(inout int n, input string what);
        @(negedge clk);
        n++;
        if (n > timeout) begin
            $display("timeout after %0d cycles waiting for %s", timeout, what);
            abort_run();
        end
    endtask

    // every read result against the reference
    always @(negedge clk) begin
        if (rstn && icache_dataok) begin
            if (exp_i.size() == 0) begin
                $display("icache_dataok pulsed with no icache read outstanding");
                abort_run();
            end
            check_word("icache_rdata", exp_i.pop_front(), icache_rdata);
        end
        if (rstn && dcache_dataok) begin
            if (exp_d.size() == 0) begin
                $display("dcache_dataok pulsed with no dcache read outstanding");
                abort_run();
            end
            check_word("dcache_rdata", exp_d.pop_front(), dcache_rdata);
        end
    end

    //////////////////////////////////////////////////
    // memory model, random 0 to 3 cycle stalls

    initial begin : memory_model
        l2_line_t line;
        l2_addr_t a;
        mem_addrok_w = 1'b0;
        mem_addrok_r = 1'b0;
        mem_dataok   = 1'b0;
        mem_rline    = '0;
        wr_count     = 0;
        rd_count     = 0;
        last_waddr   = '0;
        last_raddr   = '0;
        forever begin
            @(negedge clk);
            if (rstn && mem_req_w) begin
                repeat ($urandom_range(0, 3)) @(posedge clk);
                @(posedge clk);
                #1 mem_addrok_w = 1'b1;
                @(negedge clk);
                check_flag("mem_req_w", 1'b1, mem_req_w);
                a = mem_waddr;
                last_waddr = a;
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    line[w] = ref_word(a + l2_addr_t'(4 * w)); // evicted line's latest data
                end
                check_line("mem_wline", line, mem_wline);
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    mem_arr[a[31:2] + 30'(w)] = mem_wline[w];
                end
                wr_count++;
                @(posedge clk);
                #1 mem_addrok_w = 1'b0;
            end else if (rstn && mem_req_r) begin
                a = mem_raddr;
                last_raddr = a;
                repeat ($urandom_range(0, 3)) @(posedge clk);
                @(posedge clk);
                #1 mem_addrok_r = 1'b1;
                @(negedge clk);
                check_flag("mem_req_r", 1'b1, mem_req_r);
                @(posedge clk);
                #1 mem_addrok_r = 1'b0;
                @(negedge clk);
                check_flag("mem_rdy", 1'b1, mem_rdy);
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    line[w] = mem_word(a + l2_addr_t'(4 * w));
                end
                repeat ($urandom_range(0, 3)) @(posedge clk);
                @(posedge clk);
                #1;
                mem_dataok = 1'b1;
                mem_rline  = line;
                rd_count++;
                @(posedge clk);
                #1 mem_dataok = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // request tasks

    task automatic read_word(input bit dside, input l2_addr_t a, input bit expect_hit);
        int n;
        @(posedge clk);
        #1;
        if (dside) begin
            dcache_req  = 1'b1;
            dcache_wr   = 1'b0;
            dcache_addr = a;
        end else begin
            icache_req  = 1'b1;
            icache_addr = a;
        end
        n = 0;
        do
            next_sample(n, "addrok of a read");
        while (!(dside ? dcache_addrok : icache_addrok));
        if (dside)
            exp_d.push_back(ref_word(a));
        else
            exp_i.push_back(ref_word(a));
        @(posedge clk);
        #1;
        dcache_req = 1'b0;
        icache_req = 1'b0;
        if (expect_hit) begin
            @(negedge clk); // one cycle after addrok
            check_flag(dside ? "dcache_dataok" : "icache_dataok", 1'b1,
                       dside ? dcache_dataok : icache_dataok);
            check_flag("mem_req_r", 1'b0, mem_req_r);
        end else begin
            n = 0;
            do
                next_sample(n, "dataok of a read");
            while (!(dside ? dcache_dataok : icache_dataok));
        end
    endtask

    task automatic write_word(input l2_addr_t a, input l2_word_t d);
        int n;
        @(posedge clk);
        #1;
        dcache_req   = 1'b1;
        dcache_wr    = 1'b1;
        dcache_addr  = a;
        dcache_wdata = d;
        n = 0;
        do
            next_sample(n, "addrok of a write");
        while (!dcache_addrok);
        shadow[a[31:2]] = d;
        @(posedge clk);
        #1;
        dcache_req = 1'b0;
        dcache_wr  = 1'b0;
        n = 0;
        do
            next_sample(n, "end of a write");
        while (op_busy);
    endtask

    task automatic run_maint(input l2_maint_e code, input l2_addr_t a);
        int n;
        n = 0;
        do
            next_sample(n, "an idle cache before maintenance");
        while (op_busy);
        @(posedge clk);
        #1;
        op_flag = 1'b1;
        op_code = code;
        op_addr = a;
        @(posedge clk);
        #1 op_flag = 1'b0;
        @(negedge clk);
        check_flag("op_busy", 1'b1, op_busy);
        n = 0;
        do
            next_sample(n, "end of maintenance");
        while (op_busy);
    endtask

    // icache and dcache raise req in the same cycle
    task automatic read_both(input l2_addr_t ia, input l2_addr_t da);
        int n;
        @(posedge clk);
        #1;
        icache_req  = 1'b1;
        icache_addr = ia;
        dcache_req  = 1'b1;
        dcache_wr   = 1'b0;
        dcache_addr = da;
        n = 0;
        do
            next_sample(n, "a grant of simultaneous reads");
        while (!(icache_addrok || dcache_addrok));
        check_flag("dcache_addrok", 1'b1, dcache_addrok);
        check_flag("icache_addrok", 1'b0, icache_addrok);
        exp_d.push_back(ref_word(da));
        @(posedge clk);
        #1 dcache_req = 1'b0;
        n = 0;
        do
            next_sample(n, "icache_addrok after the dcache grant");
        while (!icache_addrok);
        exp_i.push_back(ref_word(ia));
        @(posedge clk);
        #1 icache_req = 1'b0;
        n = 0;
        do
            next_sample(n, "both read results");
        while (exp_i.size() != 0 || exp_d.size() != 0);
    endtask

    //////////////////////////////////////////////////
    // stimulus

    initial begin : stimulus
        l2_addr_t a;
        int       snap;
        void'($urandom(32'h2bc46be2));
        clk          = 1'b0;
        rstn         = 1'b0;
        icache_req   = 1'b0;
        icache_addr  = '0;
        dcache_req   = 1'b0;
        dcache_wr    = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        op_flag      = 1'b0;
        op_code      = op_index_inv;
        op_addr      = '0;
        repeat (10) @(posedge clk);
        #1 rstn = 1'b1;

        // quiet after reset
        repeat (20) begin
            @(negedge clk);
            check_flag("icache_addrok", 1'b0, icache_addrok);
            check_flag("dcache_addrok", 1'b0, dcache_addrok);
            check_flag("icache_dataok", 1'b0, icache_dataok);
            check_flag("dcache_dataok", 1'b0, dcache_dataok);
            check_flag("mem_req_w", 1'b0, mem_req_w);
            check_flag("mem_req_r", 1'b0, mem_req_r);
            check_flag("mem_rdy", 1'b0, mem_rdy);
            check_flag("op_busy", 1'b0, op_busy);
        end

        // read hits on both ports
        read_word(1'b0, make_addr(1, 5, 0), 1'b0);
        read_word(1'b0, make_addr(1, 5, 1), 1'b1);
        read_word(1'b1, make_addr(2, 6, 0), 1'b0);
        read_word(1'b1, make_addr(2, 6, 3), 1'b1);

        // write miss, then the whole line read back
        write_word(make_addr(32'h12, 9, 2), 32'hcafe_0042);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            read_word(1'b1, make_addr(32'h12, 9, w), 1'b1);
        end

        // six tags fight over the four ways of set 3
        for (int i = 0; i < 80; i++) begin
            a = make_addr(32'h40 + $urandom_range(0, 5), 3, $urandom_range(0, 3));
            case ($urandom_range(0, 2))
                0: read_word(1'b0, a, 1'b0);
                1: read_word(1'b1, a, 1'b0);
                default: write_word(a, $urandom());
            endcase
        end

        //////////////////////////////////////////////////
        // maintenance on set 3

        for (int w = 0; w < WAYS; w++) begin
            run_maint(op_index_wb_inv, index_op_addr(3, w)); // empty the set
        end
        write_word(make_addr(32'h77, 3, 1), 32'h0bad_f00d);
        snap = wr_count;
        for (int w = 0; w < WAYS; w++) begin
            run_maint(op_index_wb_inv, index_op_addr(3, w));
        end
        check_count("memory writes of index_wb_inv", snap + 1, wr_count);
        check_addr("mem_waddr", make_addr(32'h77, 3, 0), last_waddr);

        read_word(1'b1, make_addr(32'h77, 3, 1), 1'b0); // clean copy back in
        snap = wr_count;
        for (int w = 0; w < WAYS; w++) begin
            run_maint(op_index_inv, index_op_addr(3, w));
        end
        check_count("memory writes of index_inv", snap, wr_count);
        snap = rd_count;
        read_word(1'b0, make_addr(32'h77, 3, 1), 1'b0);
        check_count("memory reads after index_inv", snap + 1, rd_count);
        check_addr("mem_raddr", make_addr(32'h77, 3, 0), last_raddr);

        snap = wr_count;
        run_maint(op_hit_wb_inv, make_addr(32'h99, 3, 0)); // not cached
        check_count("memory writes of hit_wb_inv on a miss", snap, wr_count);
        write_word(make_addr(32'h55, 3, 0), 32'h1234_abcd);
        snap = wr_count;
        run_maint(op_hit_wb_inv, make_addr(32'h55, 3, 0));
        check_count("memory writes of hit_wb_inv on a dirty hit", snap + 1, wr_count);
        check_addr("mem_waddr", make_addr(32'h55, 3, 0), last_waddr);

        // dcache wins a tie
        read_both(make_addr(1, 5, 2), make_addr(32'h12, 9, 1));
        read_both(make_addr(32'h30, 7, 0), make_addr(32'h31, 7, 3));

        repeat (5) @(posedge clk);
        if (exp_i.size() == 0 && exp_d.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("read results still outstanding at the end of the run");
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* all.f */
hw/l2_geom_pkg.sv
hw/l2_ctrl_pkg.sv
hw/l2_ifs.sv
hw/l2_req_arbiter.sv
hw/l2_tag_store.sv
hw/l2_data_store.sv
hw/l2_main_fsm.sv
hw/l2_cache_top.sv
verification/l2_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the l2 cache testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module l2_cache_tb -f all.f -o l2_sim || exit 1
./obj_dir/l2_sim > sim.log 2>&1
cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
